// ==== hdl/advtim_reg_pkg.sv ====
//==================================================
// register map of the timer
// bus types for the APB-style setup/access protocol,
// register offsets and the interrupt source vector
//==================================================

`default_nettype none

package advtim_reg_pkg;

	typedef logic [7:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// one bus transfer as seen by the register block
	typedef struct packed {
		reg_addr_t paddr;
		logic      pwrite;
		logic      psel;
		logic      penable;
		reg_data_t pwdata;
	} apb_req_t;

	//==================================================
	// register offsets
	//==================================================

	// bit 0 start, bit 1 stop, reads back running
	localparam reg_addr_t ADDR_CTRL    = 8'h00;
	localparam reg_addr_t ADDR_PSC     = 8'h04;
	localparam reg_addr_t ADDR_ARR     = 8'h08;
	localparam reg_addr_t ADDR_CC1     = 8'h0C;
	localparam reg_addr_t ADDR_CC2     = 8'h10;
	localparam reg_addr_t ADDR_CC3     = 8'h14;
	// four config bits per channel
	localparam reg_addr_t ADDR_CHCFG   = 8'h18;
	localparam reg_addr_t ADDR_DTG     = 8'h1C;
	// bit 0 enable, bit 1 polarity
	localparam reg_addr_t ADDR_BRK     = 8'h20;
	localparam reg_addr_t ADDR_INT_EN  = 8'h24;
	// write one to clear
	localparam reg_addr_t ADDR_INT_STA = 8'h28;

	// bit 0 update event, bit 1 fault
	localparam int INT_W = 2;

	typedef logic [INT_W-1:0] int_vec_t;

endpackage

`default_nettype wire

// ==== hdl/advtim_gen_pkg.sv ====
//==================================================
// PWM generator definitions
// counter and dead-time widths, channel count,
// per-channel config and pin structs
//==================================================

`default_nettype none

package advtim_gen_pkg;

	localparam int CNT_W  = 16;
	localparam int DTG_W  = 8;
	localparam int NUM_CH = 3;

	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [DTG_W-1:0] dtg_t;

	// output enable and polarity of the pin pair
	typedef struct packed {
		logic en_p;
		logic en_n;
		logic pol_p;
		logic pol_n;
	} ch_cfg_t;

	// pin levels, oen is active low
	typedef struct packed {
		logic p;
		logic n;
		logic oen_p;
		logic oen_n;
	} ch_out_t;

	// shadow values seen by the counter
	typedef struct packed {
		cnt_t psc;
		cnt_t arr;
	} gen_cfg_t;

	typedef struct packed {
		logic en;
		logic pol;
	} brk_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/advtim_regs.sv ====
//==================================================
// bus register block of the timer
// preload and shadow registers, start/stop pulses,
// interrupt enable/status and read mux
//==================================================

`default_nettype none

module advtim_regs
(
	input  logic                     module_clk,
	input  logic                     module_rstn,

	input  advtim_reg_pkg::apb_req_t apb_req,
	output advtim_reg_pkg::reg_data_t prdata,

	output logic                     start,
	output logic                     stop,
	input  logic                     running,
	input  logic                     update,
	input  logic                     fault,

	output advtim_gen_pkg::gen_cfg_t gen_cfg,
	output advtim_gen_pkg::brk_cfg_t brk_cfg,
	output advtim_gen_pkg::cnt_t     cc     [advtim_gen_pkg::NUM_CH],
	output advtim_gen_pkg::ch_cfg_t  ch_cfg [advtim_gen_pkg::NUM_CH],
	output advtim_gen_pkg::dtg_t     dtg,

	output logic                     int_line
);

	import advtim_reg_pkg::*;
	import advtim_gen_pkg::*;

	logic     wr_en;
	logic     rd_en;
	gen_cfg_t gen_pre;
	cnt_t     cc_pre [NUM_CH];
	dtg_t     dtg_pre;
	int_vec_t int_en;
	int_vec_t int_sta;
	int_vec_t int_set;
	int_vec_t int_clr;

	assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite;
	assign rd_en = apb_req.psel & apb_req.penable & ~apb_req.pwrite;

	//==================================================
	// bus writes
	//==================================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			gen_pre <= '0;
			cc_pre  <= '{default: '0};
			ch_cfg  <= '{default: '0};
			dtg_pre <= '0;
			brk_cfg <= '0;
			int_en  <= '0;
		end
		else if (wr_en)
		begin
			case (apb_req.paddr)
				ADDR_PSC:    gen_pre.psc <= apb_req.pwdata[CNT_W-1:0];
				ADDR_ARR:    gen_pre.arr <= apb_req.pwdata[CNT_W-1:0];
				ADDR_CC1:    cc_pre[0]   <= apb_req.pwdata[CNT_W-1:0];
				ADDR_CC2:    cc_pre[1]   <= apb_req.pwdata[CNT_W-1:0];
				ADDR_CC3:    cc_pre[2]   <= apb_req.pwdata[CNT_W-1:0];
				ADDR_CHCFG:
				begin
					for (int i = 0; i < NUM_CH; i++)
						ch_cfg[i] <= apb_req.pwdata[i*$bits(ch_cfg_t) +: $bits(ch_cfg_t)];
				end
				ADDR_DTG:    dtg_pre     <= apb_req.pwdata[DTG_W-1:0];
				ADDR_BRK:
				begin
					brk_cfg.en  <= apb_req.pwdata[0];
					brk_cfg.pol <= apb_req.pwdata[1];
				end
				ADDR_INT_EN: int_en      <= apb_req.pwdata[INT_W-1:0];
				default:     ;
			endcase
		end
	end

	// control bits become single-cycle pulses
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			start <= 1'b0;
			stop  <= 1'b0;
		end
		else
		begin
			start <= wr_en && (apb_req.paddr == ADDR_CTRL) && apb_req.pwdata[0];
			stop  <= wr_en && (apb_req.paddr == ADDR_CTRL) && apb_req.pwdata[1];
		end
	end

	//==================================================
	// shadow registers
	//==================================================

	// follow the preload while stopped, else only at wrap
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			gen_cfg <= '0;
			cc      <= '{default: '0};
			dtg     <= '0;
		end
		else if (update || !running)
		begin
			gen_cfg <= gen_pre;
			cc      <= cc_pre;
			dtg     <= dtg_pre;
		end
	end

	//==================================================
	// interrupts
	//==================================================

	assign int_set = {fault, update};
	assign int_clr = (wr_en && (apb_req.paddr == ADDR_INT_STA)) ?
		apb_req.pwdata[INT_W-1:0] : '0;

	// a new event wins over a clear in the same cycle
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			int_sta <= '0;
		else
			int_sta <= (int_sta & ~int_clr) | int_set;
	end

	assign int_line = |(int_sta & int_en);

	// read mux
	always_comb
	begin
		prdata = '0;
		if (rd_en)
		begin
			case (apb_req.paddr)
				ADDR_CTRL:    prdata[0]         = running;
				ADDR_PSC:     prdata[CNT_W-1:0] = gen_pre.psc;
				ADDR_ARR:     prdata[CNT_W-1:0] = gen_pre.arr;
				ADDR_CC1:     prdata[CNT_W-1:0] = cc_pre[0];
				ADDR_CC2:     prdata[CNT_W-1:0] = cc_pre[1];
				ADDR_CC3:     prdata[CNT_W-1:0] = cc_pre[2];
				ADDR_CHCFG:
				begin
					for (int i = 0; i < NUM_CH; i++)
						prdata[i*$bits(ch_cfg_t) +: $bits(ch_cfg_t)] = ch_cfg[i];
				end
				ADDR_DTG:     prdata[DTG_W-1:0] = dtg_pre;
				ADDR_BRK:
				begin
					prdata[0] = brk_cfg.en;
					prdata[1] = brk_cfg.pol;
				end
				ADDR_INT_EN:  prdata[INT_W-1:0] = int_en;
				ADDR_INT_STA: prdata[INT_W-1:0] = int_sta;
				default:      ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/advtim_gen_counter.sv ====
//==================================================
// run control and time base
// break synchronizer and fault latch,
// prescaler and auto-reload up-counter
//==================================================

`default_nettype none

module advtim_gen_counter
(
	input  logic                     module_clk,
	input  logic                     module_rstn,

	input  logic                     start,
	input  logic                     stop,
	input  advtim_gen_pkg::gen_cfg_t gen_cfg,
	input  advtim_gen_pkg::brk_cfg_t brk_cfg,
	input  logic                     brk_pin,

	output logic                     running,
	output logic                     update,
	output logic                     fault,
	output advtim_gen_pkg::cnt_t     cnt,
	output logic                     brk_active
);

	import advtim_gen_pkg::*;

	logic [1:0] brk_sync;
	logic       brk_hit;
	logic       tick;
	logic       wrap;
	cnt_t       psc_cnt;

	//==================================================
	// break input
	//==================================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			brk_sync <= 2'b00;
		else
			brk_sync <= {brk_sync[0], brk_pin};
	end

	assign brk_hit = brk_cfg.en && (brk_sync[1] == brk_cfg.pol);

	// latched fault, released only by a start once the pin is quiet
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			brk_active <= 1'b0;
			fault      <= 1'b0;
		end
		else
		begin
			fault <= brk_hit && !brk_active;
			if (brk_hit)
				brk_active <= 1'b1;
			else if (start)
				brk_active <= 1'b0;
		end
	end

	// stop and break take priority over start
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			running <= 1'b0;
		else if (stop || brk_hit)
			running <= 1'b0;
		else if (start)
			running <= 1'b1;
	end

	//==================================================
	// prescaler and counter
	//==================================================

	assign tick   = running && (psc_cnt >= gen_cfg.psc);
	assign wrap   = tick && (cnt >= gen_cfg.arr);
	assign update = start || wrap;

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			psc_cnt <= '0;
			cnt     <= '0;
		end
		else if (start)
		begin
			psc_cnt <= '0;
			cnt     <= '0;
		end
		else if (running)
		begin
			psc_cnt <= tick ? '0 : psc_cnt + 1'b1;
			if (wrap)
				cnt <= '0;
			else if (tick)
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/advtim_gen_channel.sv ====
//==================================================
// one compare channel
// PWM reference, dead-time insertion on the
// complementary pair, polarity and break gating
//==================================================

`default_nettype none

module advtim_gen_channel
(
	input  logic                    module_clk,
	input  logic                    module_rstn,

	input  logic                    running,
	input  logic                    brk_active,
	input  advtim_gen_pkg::cnt_t    cnt,
	input  advtim_gen_pkg::cnt_t    cc,
	input  advtim_gen_pkg::ch_cfg_t cfg,
	input  advtim_gen_pkg::dtg_t    dtg,

	output advtim_gen_pkg::ch_out_t ch_out
);

	import advtim_gen_pkg::*;

	logic    oc_ref;
	logic    oc_ref_q;
	logic    oc_edge;
	logic    dead_done;
	logic    p_lvl;
	logic    n_lvl;
	dtg_t    dt_cnt;
	dtg_t    dt_next;
	ch_out_t out_next;

	// high while the counter is below the compare value
	assign oc_ref  = running && (cnt < cc);
	assign oc_edge = oc_ref != oc_ref_q;

	//==================================================
	// dead time
	//==================================================

	// every reference edge restarts the dead-time count
	assign dt_next   = oc_edge ? dtg : ((dt_cnt != '0) ? dt_cnt - 1'b1 : '0);
	assign dead_done = (dt_next == '0);

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			oc_ref_q <= 1'b0;
			dt_cnt   <= '0;
		end
		else
		begin
			oc_ref_q <= oc_ref;
			dt_cnt   <= dt_next;
		end
	end

	// falling side drops at once, rising side waits
	assign p_lvl = oc_ref && dead_done;
	assign n_lvl = !oc_ref && dead_done;

	//==================================================
	// polarity, enables and break
	//==================================================

	always_comb
	begin
		if (!running || brk_active)
		begin
			// inactive levels, pins released
			out_next.p     = cfg.pol_p;
			out_next.n     = cfg.pol_n;
			out_next.oen_p = 1'b1;
			out_next.oen_n = 1'b1;
		end
		else
		begin
			out_next.p     = p_lvl ^ cfg.pol_p;
			out_next.n     = n_lvl ^ cfg.pol_n;
			out_next.oen_p = !cfg.en_p;
			out_next.oen_n = !cfg.en_n;
		end
	end

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			ch_out <= '{p: 1'b0, n: 1'b0, oen_p: 1'b1, oen_n: 1'b1};
		else
			ch_out <= out_next;
	end

endmodule

`default_nettype wire

// ==== hdl/advtim_top.sv ====
//==================================================
// timer top level
// register block, time base and the three
// complementary compare channels
//==================================================

`default_nettype none

module advtim_top
(
	input  logic                      module_clk,
	input  logic                      module_rstn,

	input  advtim_reg_pkg::apb_req_t  apb_req,
	output advtim_reg_pkg::reg_data_t prdata,

	input  logic                      brk_pin,
	output advtim_gen_pkg::ch_out_t   ch_out [advtim_gen_pkg::NUM_CH],

	output logic                      int_line
);

	import advtim_gen_pkg::*;

	logic     start;
	logic     stop;
	logic     running;
	logic     update;
	logic     fault;
	logic     brk_active;
	cnt_t     cnt;
	gen_cfg_t gen_cfg;
	brk_cfg_t brk_cfg;
	cnt_t     cc     [NUM_CH];
	ch_cfg_t  ch_cfg [NUM_CH];
	dtg_t     dtg;

	advtim_regs advtim_regs_inst
	(
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.apb_req     (apb_req),
		.prdata      (prdata),
		.start       (start),
		.stop        (stop),
		.running     (running),
		.update      (update),
		.fault       (fault),
		.gen_cfg     (gen_cfg),
		.brk_cfg     (brk_cfg),
		.cc          (cc),
		.ch_cfg      (ch_cfg),
		.dtg         (dtg),
		.int_line    (int_line)
	);

	advtim_gen_counter advtim_gen_counter_inst
	(
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.start       (start),
		.stop        (stop),
		.gen_cfg     (gen_cfg),
		.brk_cfg     (brk_cfg),
		.brk_pin     (brk_pin),
		.running     (running),
		.update      (update),
		.fault       (fault),
		.cnt         (cnt),
		.brk_active  (brk_active)
	);

	//==================================================
	// compare channels
	//==================================================

	for (genvar i = 0; i < NUM_CH; i++)
	begin : gen_ch
		advtim_gen_channel advtim_gen_channel_inst
		(
			.module_clk  (module_clk),
			.module_rstn (module_rstn),
			.running     (running),
			.brk_active  (brk_active),
			.cnt         (cnt),
			.cc          (cc[i]),
			.cfg         (ch_cfg[i]),
			.dtg         (dtg),
			.ch_out      (ch_out[i])
		);
	end

endmodule

`default_nettype wire

// ==== bench/advtim_tb.sv ====
//==================================================
// testbench of the timer top level
// bus driver tasks, random configurations, expected
// values from the timing rules, typed compare tasks
// and a cycle-count watchdog
//==================================================

`default_nettype none

module advtim_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import advtim_reg_pkg::*;
	import advtim_gen_pkg::*;

	// 8 configs x 3 channels x 2 periods of at most 256 cycles,
	// 4 dead-time runs, the short tests and margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic      module_clk;
	logic      module_rstn;
	apb_req_t  apb_req;
	reg_data_t prdata;
	logic      brk_pin;
	ch_out_t   ch_out [NUM_CH];
	logic      int_line;

	integer    seed = 32'h95af_fa0a;
	int        cycles = 0;
	ch_cfg_t   cfg [NUM_CH];

	advtim_top advtim_top_inst
	(
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.apb_req     (apb_req),
		.prdata      (prdata),
		.brk_pin     (brk_pin),
		.ch_out      (ch_out),
		.int_line    (int_line)
	);

	initial
	begin
		module_clk = 1'b0;
		forever #2 module_clk = ~module_clk;
	end

	//==================================================
	// helpers
	//==================================================

	task automatic stop_on_failure();
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge module_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout, no result after %0d cycles", cycles);
			stop_on_failure();
		end
	end

	task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_out(input string name, input ch_out_t got, input ch_out_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// setup cycle, access cycle, then idle
	task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
		@(negedge module_clk);
		apb_req = '{paddr: addr, pwrite: 1'b1, psel: 1'b1, penable: 1'b0, pwdata: data};
		@(negedge module_clk);
		apb_req.penable = 1'b1;
		@(negedge module_clk);
		apb_req = '0;
	endtask

	task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
		@(negedge module_clk);
		apb_req = '{paddr: addr, pwrite: 1'b0, psel: 1'b1, penable: 1'b0, pwdata: '0};
		@(negedge module_clk);
		apb_req.penable = 1'b1;
		// mid access cycle, prdata settled
		#1 data = prdata;
		@(negedge module_clk);
		apb_req = '0;
	endtask

	task automatic write_chcfg();
		bus_write(ADDR_CHCFG, {20'd0, cfg[2], cfg[1], cfg[0]});
	endtask

	// active level with polarity taken out
	function automatic logic act_level(input int ch, input bit is_p);
		return is_p ? (ch_out[ch].p ^ cfg[ch].pol_p) : (ch_out[ch].n ^ cfg[ch].pol_n);
	endfunction

	function automatic bit all_released();
		bit rel;
		rel = 1'b1;
		for (int i = 0; i < NUM_CH; i++)
			rel = rel && ch_out[i].oen_p && ch_out[i].oen_n;
		return rel;
	endfunction

	task automatic check_overlap(input int ch);
		if (act_level(ch, 1'b1) && act_level(ch, 1'b0))
		begin
			$display("channel %0d drives p and n active in the same cycle", ch);
			stop_on_failure();
		end
	endtask

	// from one p rising edge to the next
	task automatic measure_p(input int ch, input ch_out_t exp_rise, output int high,
		output int period);
		logic prev;
		prev = ch_out[ch].p;
		@(negedge module_clk);
		while (prev || !ch_out[ch].p)
		begin
			prev = ch_out[ch].p;
			@(negedge module_clk);
		end
		check_out($sformatf("ch_out[%0d] at p rise", ch), ch_out[ch], exp_rise);
		high = 0;
		period = 0;
		while (ch_out[ch].p)
		begin
			high++;
			period++;
			@(negedge module_clk);
		end
		while (!ch_out[ch].p)
		begin
			period++;
			@(negedge module_clk);
		end
	endtask

	// cycles from one side going inactive to the other going active
	task automatic dead_gap(input int ch, input bit from_p, output int gap);
		logic prev;
		prev = act_level(ch, from_p);
		@(negedge module_clk);
		while (!(prev && !act_level(ch, from_p)))
		begin
			check_overlap(ch);
			prev = act_level(ch, from_p);
			@(negedge module_clk);
		end
		gap = 0;
		while (!act_level(ch, !from_p))
		begin
			check_overlap(ch);
			@(negedge module_clk);
			gap++;
		end
		check_overlap(ch);
	endtask

	//==================================================
	// stimulus
	//==================================================

	initial
	begin
		reg_addr_t regs  [9];
		reg_data_t masks [9];
		reg_data_t wr    [9];
		reg_data_t rd;
		cnt_t      cc_val [NUM_CH];
		int        psc;
		int        arr;
		int        dtg;
		int        high;
		int        period;
		int        gap;
		int        ch;
		int        n;
		logic      pol;

		module_rstn = 1'b0;
		apb_req     = '0;
		brk_pin     = 1'b0;
		repeat (3) @(negedge module_clk);
		module_rstn = 1'b1;

		// register readback
		bus_read(ADDR_CTRL, rd);
		check_data("CTRL after reset", rd, 32'h0);
		regs  = '{ADDR_PSC, ADDR_ARR, ADDR_CC1, ADDR_CC2, ADDR_CC3, ADDR_CHCFG, ADDR_DTG,
			ADDR_BRK, ADDR_INT_EN};
		masks = '{32'hFFFF, 32'hFFFF, 32'hFFFF, 32'hFFFF, 32'hFFFF, 32'hFFF, 32'hFF,
			32'h3, 32'h3};
		for (int i = 0; i < 9; i++)
		begin
			wr[i] = $random(seed);
			bus_write(regs[i], wr[i]);
		end
		for (int i = 0; i < 9; i++)
		begin
			bus_read(regs[i], rd);
			check_data($sformatf("reg 0x%02h", regs[i]), rd, wr[i] & masks[i]);
		end
		bus_write(ADDR_BRK, 32'h0);
		bus_write(ADDR_INT_EN, 32'h0);

		// period and duty, dtg 0, positive polarity
		for (int k = 0; k < 8; k++)
		begin
			psc = rand_below(4);
			arr = 1 + rand_below(63);
			for (int i = 0; i < NUM_CH; i++)
			begin
				cc_val[i] = 1 + rand_below(arr);
				cfg[i] = '{en_p: 1'(rand_below(2)), en_n: 1'(rand_below(2)),
					pol_p: 1'b0, pol_n: 1'b0};
				bus_write(reg_addr_t'(ADDR_CC1 + 4 * i), cc_val[i]);
			end
			bus_write(ADDR_PSC, psc);
			bus_write(ADDR_ARR, arr);
			bus_write(ADDR_DTG, 32'h0);
			write_chcfg();
			bus_write(ADDR_CTRL, 32'h1);
			for (int i = 0; i < NUM_CH; i++)
			begin
				measure_p(i, '{p: 1'b1, n: 1'b0, oen_p: !cfg[i].en_p, oen_n: !cfg[i].en_n},
					high, period);
				check_count($sformatf("period ch%0d", i), period, (psc + 1) * (arr + 1));
				n = (cc_val[i] < arr + 1) ? cc_val[i] : arr + 1;
				check_count($sformatf("high time ch%0d", i), high, (psc + 1) * n);
			end
			bus_write(ADDR_CTRL, 32'h2);
		end

		// dead time, phases kept longer than the largest dtg
		for (int k = 0; k < 4; k++)
		begin
			psc = rand_below(4);
			arr = 16 + rand_below(48);
			dtg = rand_below(8);
			for (int i = 0; i < NUM_CH; i++)
			begin
				cc_val[i] = 8 + rand_below(arr - 15);
				cfg[i] = '{en_p: 1'b1, en_n: 1'b1, pol_p: 1'(rand_below(2)),
					pol_n: 1'(rand_below(2))};
				bus_write(reg_addr_t'(ADDR_CC1 + 4 * i), cc_val[i]);
			end
			bus_write(ADDR_PSC, psc);
			bus_write(ADDR_ARR, arr);
			bus_write(ADDR_DTG, dtg);
			write_chcfg();
			ch = rand_below(NUM_CH);
			bus_write(ADDR_CTRL, 32'h1);
			dead_gap(ch, 1'b1, gap);
			check_count($sformatf("dead time p to n ch%0d", ch), gap, dtg);
			dead_gap(ch, 1'b0, gap);
			check_count($sformatf("dead time n to p ch%0d", ch), gap, dtg);
			bus_write(ADDR_CTRL, 32'h2);
		end

		// update interrupt
		bus_write(ADDR_INT_STA, 32'h3);
		bus_write(ADDR_INT_EN, 32'h1);
		check_data("int_line while idle", {31'd0, int_line}, 32'h0);
		bus_write(ADDR_CTRL, 32'h1);
		while (!int_line)
			@(negedge module_clk);
		bus_read(ADDR_INT_STA, rd);
		check_data("INT_STA after start", rd, 32'h1);
		bus_write(ADDR_CTRL, 32'h2);
		bus_write(ADDR_INT_STA, 32'h1);
		@(negedge module_clk);
		check_data("int_line after clear", {31'd0, int_line}, 32'h0);
		bus_read(ADDR_INT_STA, rd);
		check_data("INT_STA after clear", rd, 32'h0);

		// break
		pol = 1'(rand_below(2));
		brk_pin = !pol;
		for (int i = 0; i < NUM_CH; i++)
			cfg[i] = '{en_p: 1'b1, en_n: 1'b1, pol_p: 1'b0, pol_n: 1'b0};
		write_chcfg();
		bus_write(ADDR_DTG, 32'h0);
		bus_write(ADDR_BRK, {30'd0, pol, 1'b1});
		bus_write(ADDR_CTRL, 32'h1);
		repeat (4) @(negedge module_clk);
		brk_pin = pol;
		// brk_active after 3 cycles, the registered pins one later
		n = 0;
		while (!all_released())
		begin
			@(negedge module_clk);
			n++;
		end
		check_count("break to release", n, 4);
		bus_read(ADDR_CTRL, rd);
		check_data("CTRL after break", rd, 32'h0);
		bus_read(ADDR_INT_STA, rd);
		check_data("INT_STA fault bit", rd & 32'h2, 32'h2);
		brk_pin = !pol;
		repeat (16)
		begin
			@(negedge module_clk);
			for (int i = 0; i < NUM_CH; i++)
				check_out($sformatf("ch_out[%0d] released", i), ch_out[i],
					'{p: 1'b0, n: 1'b0, oen_p: 1'b1, oen_n: 1'b1});
		end
		bus_write(ADDR_CTRL, 32'h1);
		repeat (2) @(negedge module_clk);
		// cnt 0 below every cc, so p active, n idle
		for (int i = 0; i < NUM_CH; i++)
			check_out($sformatf("ch_out[%0d] after restart", i), ch_out[i],
				'{p: 1'b1, n: 1'b0, oen_p: 1'b0, oen_n: 1'b0});
		bus_read(ADDR_CTRL, rd);
		check_data("CTRL after restart", rd, 32'h1);
		bus_write(ADDR_CTRL, 32'h2);

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/advtim_reg_pkg.sv
hdl/advtim_gen_pkg.sv
hdl/advtim_regs.sv
hdl/advtim_gen_counter.sv
hdl/advtim_gen_channel.sv
hdl/advtim_top.sv
bench/advtim_tb.sv

// ==== Bender.yml ====
package:
  name: advtim

sources:
  - hdl/advtim_reg_pkg.sv
  - hdl/advtim_gen_pkg.sv
  - hdl/advtim_regs.sv
  - hdl/advtim_gen_counter.sv
  - hdl/advtim_gen_channel.sv
  - hdl/advtim_top.sv
  - target: test
    files:
      - bench/advtim_tb.sv
